//--- filelist.f
+incdir+include
logic/prince_pkg.sv
logic/prince_pre_whiten.sv
logic/prince_fwd_round.sv
logic/prince_middle.sv
logic/prince_rev_round.sv
logic/prince_post_whiten.sv
logic/prince_top.sv
verification/tb_prince.sv

//--- logic/prince_fwd_round.sv
// ##########################################################
// PRINCE forward round R1..R5
// S layer, M = SR * M', then RC and K1 addition, registered
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_fwd_round
#(
    parameter int round_idx = 1              // 1 .. HALF_ROUNDS
)
(
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire prince_pkg::block_t  state_in,
    input  wire prince_pkg::block_t  k1_in,
    input  wire prince_pkg::block_t  k0p_in,
    input  wire                      valid_in,
    output prince_pkg::block_t       state_out,
    output prince_pkg::block_t       k1_out,
    output prince_pkg::block_t       k0p_out,
    output logic                     valid_out
);

    prince_pkg::block_t sub_out;
    prince_pkg::block_t lin_out;
    prince_pkg::block_t rnd_out;

    assign sub_out = prince_pkg::s_layer(state_in);
    assign lin_out = prince_pkg::shift_rows(prince_pkg::m_prime(sub_out));  // M' first, then SR
    assign rnd_out = lin_out ^ prince_pkg::RC[round_idx] ^ k1_in;

    always_ff @(posedge clk)
    begin
        if (sys_rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        if (valid_in)
        begin
            state_out <= rnd_out;
            k1_out    <= k1_in;        // Key sideband rides with its block
            k0p_out   <= k0p_in;
        end
    end

    // Valid chain stays known once reset has flushed it
    a_valid_known: assert property (
        @(posedge clk) disable iff (sys_rst) !$isunknown(valid_out)
    ) else $error("valid_out unknown in forward round %0d", round_idx);

endmodule

`default_nettype wire

//--- logic/prince_middle.sv
// ##########################################################
// PRINCE middle layer
// S, M', S inverse with no key or constant, registered
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_middle
(
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire prince_pkg::block_t  state_in,
    input  wire prince_pkg::block_t  k1_in,
    input  wire prince_pkg::block_t  k0p_in,
    input  wire                      valid_in,
    output prince_pkg::block_t       state_out,
    output prince_pkg::block_t       k1_out,
    output prince_pkg::block_t       k0p_out,
    output logic                     valid_out
);

    prince_pkg::block_t sub_out;
    prince_pkg::block_t lin_out;

    // Involutive core, no shift rows here
    assign sub_out = prince_pkg::s_layer(state_in);
    assign lin_out = prince_pkg::m_prime(sub_out);

    always_ff @(posedge clk)
    begin
        if (sys_rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        if (valid_in)
        begin
            state_out <= prince_pkg::s_inv_layer(lin_out);
            k1_out    <= k1_in;
            k0p_out   <= k0p_in;      // Unused until post-whitening
        end
    end

endmodule

`default_nettype wire

//--- logic/prince_pkg.sv
// ##########################################################
// PRINCE shared definitions
// Widths, block type, S-box, shift-row and round constant tables
// Round layer functions used by every pipeline stage
// ##########################################################
`default_nettype none

package prince_pkg;

    localparam int BLOCK_W     = 64;
    localparam int KEY_W       = 128;
    localparam int NIBBLE_W    = 4;
    localparam int NUM_NIBBLES = 16;
    localparam int HALF_ROUNDS = 5;          // Rounds on each side of the middle layer

    typedef logic [BLOCK_W-1:0] block_t;

    // RC0 .. RC11, RCi ^ RC(11-i) is the alpha constant
    localparam block_t RC [0:11] = '{
        64'h0000000000000000, 64'h13198a2e03707344, 64'ha4093822299f31d0,
        64'h082efa98ec4e6c89, 64'h452821e638d01377, 64'hbe5466cf34e90c6c,
        64'h7ef84f78fd955cb1, 64'h85840851f1ac43aa, 64'hc882d32f25323c54,
        64'h64a51195e0e3610d, 64'hd3b5a399ca0c2399, 64'hc0ac29b7c97c50dd
    };

    localparam logic [NIBBLE_W-1:0] SBOX [0:NUM_NIBBLES-1] = '{
        4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
        4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
    };
    localparam logic [NIBBLE_W-1:0] SBOX_INV [0:NUM_NIBBLES-1] = '{
        4'hB, 4'h7, 4'h3, 4'h2, 4'hF, 4'hD, 4'h8, 4'h9,
        4'hA, 4'h6, 4'h4, 4'h0, 4'h5, 4'hE, 4'hC, 4'h1
    };

    // Output nibble i takes input nibble SR[i], nibble 0 is the MSB nibble
    localparam int SR     [0:NUM_NIBBLES-1] = '{0, 5, 10, 15, 4, 9, 14, 3,
                                                8, 13, 2, 7, 12, 1, 6, 11};
    localparam int SR_INV [0:NUM_NIBBLES-1] = '{0, 13, 10, 7, 4, 1, 14, 11,
                                                8, 5, 2, 15, 12, 9, 6, 3};

    // m0..m3 diagonal masks, bit 3 of the nibble is position 0
    localparam logic [NIBBLE_W-1:0] M_MASK [0:3] = '{4'b0111, 4'b1011, 4'b1101, 4'b1110};

    function automatic logic [NIBBLE_W-1:0] get_nibble(block_t b, int idx);
        return b[BLOCK_W-1-NIBBLE_W*idx -: NIBBLE_W];
    endfunction

    function automatic block_t sub_nibbles(block_t b, logic inv);
        block_t r;
        for (int i = 0; i < NUM_NIBBLES; i++)
            r[NIBBLE_W*i +: NIBBLE_W] = inv ? SBOX_INV[b[NIBBLE_W*i +: NIBBLE_W]]
                                            : SBOX[b[NIBBLE_W*i +: NIBBLE_W]];
        return r;
    endfunction

    function automatic block_t nibble_perm(block_t b, logic inv);
        block_t r;
        int src;
        for (int i = 0; i < NUM_NIBBLES; i++)
        begin
            src = inv ? SR_INV[i] : SR[i];
            r[BLOCK_W-1-NIBBLE_W*i -: NIBBLE_W] = get_nibble(b, src);
        end
        return r;
    endfunction

    function automatic block_t s_layer(block_t b);
        return sub_nibbles(b, 1'b0);
    endfunction

    function automatic block_t s_inv_layer(block_t b);
        return sub_nibbles(b, 1'b1);
    endfunction

    function automatic block_t shift_rows(block_t b);
        return nibble_perm(b, 1'b0);
    endfunction

    function automatic block_t shift_rows_inv(block_t b);
        return nibble_perm(b, 1'b1);
    endfunction

    // Block diagonal M0^, M1^, M1^, M0^ over the four 16-bit chunks
    function automatic block_t m_prime(block_t b);
        block_t r;
        logic [NIBBLE_W-1:0] acc;
        int hat;
        for (int q = 0; q < 4; q++)
        begin
            hat = (q == 1 || q == 2) ? 1 : 0;    // Inner chunks use M1^
            for (int row = 0; row < 4; row++)
            begin
                acc = '0;
                for (int col = 0; col < 4; col++)
                    acc ^= get_nibble(b, 4*q + col) & M_MASK[(row + col + hat) % 4];
                r[BLOCK_W-1-NIBBLE_W*(4*q+row) -: NIBBLE_W] = acc;
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

//--- logic/prince_post_whiten.sv
// ##########################################################
// PRINCE output stage
// RC11, K1 and K0' whitening into the ciphertext register
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_post_whiten
(
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire prince_pkg::block_t  state_in,
    input  wire prince_pkg::block_t  k1_in,
    input  wire prince_pkg::block_t  k0p_in,
    input  wire                      valid_in,
    output prince_pkg::block_t       cipher_text,
    output logic                     out_valid
);

    always_ff @(posedge clk)
    begin
        if (sys_rst)
            out_valid <= 1'b0;
        else
            out_valid <= valid_in;
    end

    // Holds the last result between blocks
    always_ff @(posedge clk)
    begin
        if (valid_in)
            cipher_text <= state_in ^ prince_pkg::RC[11] ^ k1_in ^ k0p_in;   // Key sideband ends here
    end

    // Whole valid chain has been flushed by reset
    a_out_valid_known: assert property (
        @(posedge clk) disable iff (sys_rst) !$isunknown(out_valid)
    ) else $error("out_valid unknown");

endmodule

`default_nettype wire

//--- logic/prince_pre_whiten.sv
// ##########################################################
// PRINCE input stage
// Key split, K0' derivation and pre-whitening register
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_pre_whiten
(
    input  wire                          clk,
    input  wire                          sys_rst,
    input  wire                          in_valid,
    input  wire [prince_pkg::KEY_W-1:0]  key,         // K1 upper half, K0 lower half
    input  wire prince_pkg::block_t      plain_text,
    output prince_pkg::block_t           state,
    output prince_pkg::block_t           k1,
    output prince_pkg::block_t           k0p,
    output logic                         valid
);

    prince_pkg::block_t k0_w;
    prince_pkg::block_t k1_w;
    prince_pkg::block_t k0p_w;

    assign k1_w = key[prince_pkg::KEY_W-1 -: prince_pkg::BLOCK_W];
    assign k0_w = key[prince_pkg::BLOCK_W-1:0];

    // K0' = (K0 >>> 1) ^ (K0 >> 63)
    assign k0p_w = {k0_w[0], k0_w[prince_pkg::BLOCK_W-1:1]}
                 ^ {{(prince_pkg::BLOCK_W-1){1'b0}}, k0_w[prince_pkg::BLOCK_W-1]};

    always_ff @(posedge clk)
    begin
        if (sys_rst)
            valid <= 1'b0;
        else
            valid <= in_valid;
    end

    // Payload only moves with a block
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            state <= plain_text ^ k0_w ^ k1_w ^ prince_pkg::RC[0];   // K0 and core whitening
            k1    <= k1_w;
            k0p   <= k0p_w;
        end
    end

endmodule

`default_nettype wire

//--- logic/prince_rev_round.sv
// ##########################################################
// PRINCE reverse round R6..R10
// RC and K1 addition, SR inverse, M', S inverse, registered
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_rev_round
#(
    parameter int round_idx = 6              // HALF_ROUNDS+1 .. 2*HALF_ROUNDS
)
(
    input  wire                      clk,
    input  wire                      sys_rst,
    input  wire prince_pkg::block_t  state_in,
    input  wire prince_pkg::block_t  k1_in,
    input  wire prince_pkg::block_t  k0p_in,
    input  wire                      valid_in,
    output prince_pkg::block_t       state_out,
    output prince_pkg::block_t       k1_out,
    output prince_pkg::block_t       k0p_out,
    output logic                     valid_out
);

    prince_pkg::block_t key_out;
    prince_pkg::block_t lin_out;

    // Key addition comes first on this side
    assign key_out = state_in ^ prince_pkg::RC[round_idx] ^ k1_in;
    assign lin_out = prince_pkg::m_prime(prince_pkg::shift_rows_inv(key_out));   // M inverse

    always_ff @(posedge clk)
    begin
        if (sys_rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        if (valid_in)
        begin
            state_out <= prince_pkg::s_inv_layer(lin_out);
            k1_out    <= k1_in;
            k0p_out   <= k0p_in;
        end
    end

    // K1 has crossed every earlier stage with the block
    a_k1_known: assert property (
        @(posedge clk) disable iff (sys_rst) valid_in |-> !$isunknown(k1_in)
    ) else $error("k1 unknown with a valid block in reverse round %0d", round_idx);

endmodule

`default_nettype wire

//--- logic/prince_top.sv
// ##########################################################
// PRINCE encryption pipeline top level
// Pre-whiten, 5 forward rounds, middle, 5 reverse rounds, post-whiten
// Thirteen stages, one block per clock
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module prince_top
(
    input  wire                          clk,
    input  wire                          sys_rst,
    input  wire                          in_valid,
    input  wire [prince_pkg::KEY_W-1:0]  key,
    input  wire prince_pkg::block_t      plain_text,
    output prince_pkg::block_t           cipher_text,
    output logic                         out_valid
);

    // Stage outputs: 0 pre-whiten, 1..5 forward, 6 middle, 7..11 reverse
    prince_pkg::block_t st_state [0:2*prince_pkg::HALF_ROUNDS+1];
    prince_pkg::block_t st_k1    [0:2*prince_pkg::HALF_ROUNDS+1];
    prince_pkg::block_t st_k0p   [0:2*prince_pkg::HALF_ROUNDS+1];
    logic               st_valid [0:2*prince_pkg::HALF_ROUNDS+1];

    prince_pre_whiten i_pre_whiten (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .in_valid   (in_valid),
        .key        (key),
        .plain_text (plain_text),
        .state      (st_state[0]),
        .k1         (st_k1[0]),
        .k0p        (st_k0p[0]),
        .valid      (st_valid[0])
    );

    // R1..R5
    for (genvar g = 0; g < prince_pkg::HALF_ROUNDS; g++)
    begin : g_fwd
        prince_fwd_round #(.round_idx(g + 1)) i_round (
            .clk       (clk),
            .sys_rst   (sys_rst),
            .state_in  (st_state[g]),
            .k1_in     (st_k1[g]),
            .k0p_in    (st_k0p[g]),
            .valid_in  (st_valid[g]),
            .state_out (st_state[g+1]),
            .k1_out    (st_k1[g+1]),
            .k0p_out   (st_k0p[g+1]),
            .valid_out (st_valid[g+1])
        );
    end

    prince_middle i_middle (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .state_in  (st_state[prince_pkg::HALF_ROUNDS]),
        .k1_in     (st_k1[prince_pkg::HALF_ROUNDS]),
        .k0p_in    (st_k0p[prince_pkg::HALF_ROUNDS]),
        .valid_in  (st_valid[prince_pkg::HALF_ROUNDS]),
        .state_out (st_state[prince_pkg::HALF_ROUNDS+1]),
        .k1_out    (st_k1[prince_pkg::HALF_ROUNDS+1]),
        .k0p_out   (st_k0p[prince_pkg::HALF_ROUNDS+1]),
        .valid_out (st_valid[prince_pkg::HALF_ROUNDS+1])
    );

    // R6..R10, fed from the middle layer slot
    for (genvar g = 0; g < prince_pkg::HALF_ROUNDS; g++)
    begin : g_rev
        prince_rev_round #(.round_idx(prince_pkg::HALF_ROUNDS + 1 + g)) i_round (
            .clk       (clk),
            .sys_rst   (sys_rst),
            .state_in  (st_state[prince_pkg::HALF_ROUNDS+1+g]),
            .k1_in     (st_k1[prince_pkg::HALF_ROUNDS+1+g]),
            .k0p_in    (st_k0p[prince_pkg::HALF_ROUNDS+1+g]),
            .valid_in  (st_valid[prince_pkg::HALF_ROUNDS+1+g]),
            .state_out (st_state[prince_pkg::HALF_ROUNDS+2+g]),
            .k1_out    (st_k1[prince_pkg::HALF_ROUNDS+2+g]),
            .k0p_out   (st_k0p[prince_pkg::HALF_ROUNDS+2+g]),
            .valid_out (st_valid[prince_pkg::HALF_ROUNDS+2+g])
        );
    end

    prince_post_whiten i_post_whiten (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .state_in    (st_state[2*prince_pkg::HALF_ROUNDS+1]),
        .k1_in       (st_k1[2*prince_pkg::HALF_ROUNDS+1]),
        .k0p_in      (st_k0p[2*prince_pkg::HALF_ROUNDS+1]),
        .valid_in    (st_valid[2*prince_pkg::HALF_ROUNDS+1]),
        .cipher_text (cipher_text),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PRINCE testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_prince \
    -f filelist.f -o tb_prince \
    && ./obj_dir/tb_prince > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- include/prince_model.svh
// ##########################################################
// Reference model of PRINCE encryption for the testbench
// Bit-level M', nibble S-box and shift rows, full cipher
// ##########################################################
`ifndef PRINCE_MODEL_SVH
`define PRINCE_MODEL_SVH

// Nibble-wise S-box, inverse table when inv is set
function automatic prince_pkg::block_t model_sbox(prince_pkg::block_t x, bit inv);
    prince_pkg::block_t r;
    logic [3:0] n;
    for (int i = 0; i < 16; i++)
    begin
        n = x[4*i +: 4];
        r[4*i +: 4] = inv ? prince_pkg::SBOX_INV[n] : prince_pkg::SBOX[n];
    end
    return r;
endfunction

// Nibble 0 at the MSB end
function automatic prince_pkg::block_t model_shift_rows(prince_pkg::block_t x, bit inv);
    prince_pkg::block_t r;
    int src;
    for (int i = 0; i < 16; i++)
    begin
        src = inv ? prince_pkg::SR_INV[i] : prince_pkg::SR[i];
        r[63-4*i -: 4] = x[63-4*src -: 4];
    end
    return r;
endfunction

// Each output bit is the XOR of three inputs of the same bit position
// Skipped input nibble depends on row, bit and M0^ or M1^ chunk
function automatic prince_pkg::block_t model_m_prime(prince_pkg::block_t x);
    prince_pkg::block_t r;
    int hat;
    int skip;
    bit acc;
    for (int q = 0; q < 4; q++)
    begin
        hat = (q == 1 || q == 2) ? 1 : 0;
        for (int row = 0; row < 4; row++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                skip = (p - row - hat + 8) % 4;
                acc = 1'b0;
                for (int col = 0; col < 4; col++)
                    if (col != skip)
                        acc ^= x[63 - (16*q + 4*col + p)];
                r[63 - (16*q + 4*row + p)] = acc;
            end
        end
    end
    return r;
endfunction

// Full encryption, key = K1 || K0
function automatic prince_pkg::block_t model_encrypt(logic [127:0] key,
                                                     prince_pkg::block_t pt);
    prince_pkg::block_t k0;
    prince_pkg::block_t k1;
    prince_pkg::block_t k0p;
    prince_pkg::block_t s;
    k1  = key[127:64];
    k0  = key[63:0];
    k0p = {k0[0], k0[63:1]} ^ (k0 >> 63);
    s = pt ^ k0 ^ k1 ^ prince_pkg::RC[0];
    for (int rnd = 1; rnd <= 5; rnd++)
        s = model_shift_rows(model_m_prime(model_sbox(s, 0)), 0) ^ prince_pkg::RC[rnd] ^ k1;
    s = model_sbox(model_m_prime(model_sbox(s, 0)), 1);
    for (int rnd = 6; rnd <= 10; rnd++)
        s = model_sbox(model_m_prime(model_shift_rows(s ^ prince_pkg::RC[rnd] ^ k1, 1)), 1);
    return s ^ prince_pkg::RC[11] ^ k1 ^ k0p;
endfunction

`endif

//--- verification/tb_prince.sv
// ##########################################################
// Testbench for the PRINCE encryption pipeline
// Known vectors, latency, streaming, per-block keys, reset
// Scoreboard queue against the reference model functions
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "prince_model.svh"

module tb_prince;

    localparam int SEED       = 38;
    localparam int LATENCY    = 13;          // in_valid edge to out_valid edge
    localparam int RST_CYCLES = 4;
    localparam int N_KAT      = 5;
    localparam int N_STREAM   = 200;
    localparam int N_GAP      = 200;
    localparam int N_ALT      = 40;
    localparam int N_RST_PRE  = 30;          // Random stream cycles before the mid-run reset
    localparam int NUM_BLOCKS = N_KAT + 1 + N_STREAM + N_GAP + N_ALT + N_RST_PRE + 1;
    localparam int TIMEOUT_CYCLES = (NUM_BLOCKS + LATENCY + RST_CYCLES) * 2;

    logic                         clk = 1'b0;
    logic                         sys_rst;
    logic                         in_valid;
    logic [prince_pkg::KEY_W-1:0] key;
    prince_pkg::block_t           plain_text;
    prince_pkg::block_t           cipher_text;
    logic                         out_valid;

    prince_pkg::block_t exp_q [$];           // Expected ciphertexts in input order
    string              name_q [$];
    string              cur_name;
    logic               use_known;           // Known vector phase
    prince_pkg::block_t known_exp;
    logic [LATENCY-1:0] hist = '0;           // Accepted blocks of the last 13 edges
    int                 errors = 0;
    int                 checks = 0;
    int                 cycle_cnt = 0;

    prince_top i_dut (
        .clk         (clk),
        .sys_rst     (sys_rst),
        .in_valid    (in_valid),
        .key         (key),
        .plain_text  (plain_text),
        .cipher_text (cipher_text),
        .out_valid   (out_valid)
    );

    always #2 clk = ~clk;                    // 4 ns period

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    function automatic prince_pkg::block_t rand_block();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [127:0] rand_key();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Inputs change 1 ns after the edge and are sampled on the next one
    task automatic send_block(input string name, input logic [127:0] k,
                              input prince_pkg::block_t pt);
        @(posedge clk);
        #1;
        in_valid   = 1'b1;
        key        = k;
        plain_text = pt;
        cur_name   = name;
        use_known  = 1'b0;
    endtask

    task automatic send_known(input string name, input prince_pkg::block_t pt,
                              input prince_pkg::block_t k0, input prince_pkg::block_t k1,
                              input prince_pkg::block_t ct);
        send_block(name, {k1, k0}, pt);
        use_known = 1'b1;                    // Scoreboard takes the published value
        known_exp = ct;
    endtask

    task automatic send_idle();
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        key        = rand_key();             // Junk payload while idle
        plain_text = rand_block();
    endtask

    task automatic drain();
        send_idle();
        while (exp_q.size() != 0)
            send_idle();
        repeat (2) send_idle();
    endtask

    task automatic apply_reset(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge clk);
            #1;
            sys_rst  = 1'b1;
            in_valid = 1'($urandom_range(1));   // Ignored while in reset
        end
        @(posedge clk);
        #1;
        sys_rst  = 1'b0;
        in_valid = 1'b0;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        check_value("valid_pattern", 64'(hist[LATENCY-1]), {63'b0, out_valid});
        if (out_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Unexpected out_valid with no block in flight");
            end
            else
                check_value(name_q.pop_front(), exp_q.pop_front(), cipher_text);
        end
        // Record what the next rising edge will accept
        if (sys_rst)
        begin
            hist = '0;                       // In-flight blocks are wiped
            exp_q.delete();
            name_q.delete();
        end
        else
        begin
            hist = {hist[LATENCY-2:0], in_valid};
            if (in_valid)
            begin
                exp_q.push_back(use_known ? known_exp : model_encrypt(key, plain_text));
                name_q.push_back(cur_name);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            errors++;
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        logic [127:0] key_a;
        logic [127:0] key_b;
        int           sent;
        int           lat;
        void'($urandom(SEED));
        sys_rst    = 1'b1;
        in_valid   = 1'b0;
        key        = '0;
        plain_text = '0;
        cur_name   = "reset";
        use_known  = 1'b0;
        known_exp  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        sys_rst = 1'b0;

        // Published vectors with the key as K1 || K0
        send_known("kat_zero", 64'h0, 64'h0, 64'h0, 64'h818665aa0d02dfda);
        send_known("kat_pt_ones", '1, 64'h0, 64'h0, 64'h604ae6ca03c20ada);
        send_known("kat_k0_ones", 64'h0, '1, 64'h0, 64'h9fb51935fc3df524);
        send_known("kat_k1_ones", 64'h0, 64'h0, '1, 64'h78a54cbe737bb7ef);
        send_known("kat_mixed", 64'h0123456789abcdef, 64'h0,
                   64'hfedcba9876543210, 64'hae25ad3ca8fa9ccf);
        drain();

        // Isolated block then count falling edges to out_valid
        send_block("latency", rand_key(), rand_block());
        send_idle();
        lat = 0;
        do
        begin
            @(negedge clk);
            lat++;
        end while (out_valid !== 1'b1 && lat < 4 * LATENCY);
        check_value("latency", 64'(LATENCY), 64'(lat));
        drain();

        for (int i = 0; i < N_STREAM; i++)
            send_block("back_to_back", rand_key(), rand_block());
        drain();

        sent = 0;
        while (sent < N_GAP)
        begin
            if ($urandom_range(99) < 70)
            begin
                send_block("gapped", rand_key(), rand_block());
                sent++;
            end
            else
                send_idle();
        end
        drain();

        key_a = rand_key();
        key_b = rand_key();
        for (int i = 0; i < N_ALT; i++)
            send_block("per_block_key", (i % 2 == 1) ? key_b : key_a, rand_block());
        drain();

        // Reset with blocks in flight
        for (int i = 0; i < N_RST_PRE; i++)
        begin
            if ($urandom_range(99) < 70)
                send_block("reset_flush", rand_key(), rand_block());
            else
                send_idle();
        end
        apply_reset(RST_CYCLES);
        send_block("after_reset", rand_key(), rand_block());
        drain();

        if (exp_q.size() != 0)
        begin
            errors++;
            $display("Blocks still expected at the end: %0d", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
